// ==== flash_core.f ====
verilog/flash_pkg.sv
verilog/flash_ctrl.sv
verilog/addr_counter.sv
verilog/page_buffer.sv
verilog/memory_array.sv
verilog/flash_core.sv
tb/flash_core_properties.sv
tb/flash_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the flash core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module flash_core_tb \
   -f flash_core.f -o flash_core_sim

# Let assertion errors be counted instead of stopping the run
status=0
./obj_dir/flash_core_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi

if [ "$status" -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi

echo "Simulation finished without failure"

// ==== tb/flash_core_properties.sv ====
// Flash core bound checks
// Read latency, busy length of each walk and write qualification

`timescale 1ns/1ps

module flash_core_properties
   import flash_pkg::*;
#(
   parameter int mem_depth  = 1024,
   parameter int page_len   = 16,
   parameter int sector_len = 256
)
(
   input logic      data_request,
   input logic      read_enable,
   input flash_op_t cmd_op,
   input logic      cmd_end,
   input logic      rd_strobe,
   input logic      addr_load,
   input logic      mem_wr,
   input logic      rd_valid,
   input logic      busy
);

   int   busy_cnt;
   int   exp_len;
   int   walk_left;
   logic reading;
   logic loading;
   logic strobe_ok;
   int   prop_errors = 0;

   // ------------------------------
   // Busy run length tracking
   // ------------------------------

   // Reset lands in the initial walk over the whole array
   always_ff @(posedge data_request or posedge read_enable)
   begin
      if (read_enable)
      begin
         busy_cnt <= 0;
         exp_len  <= mem_depth;
      end
      else
      begin
         busy_cnt <= busy ? busy_cnt + 1 : 0;
         if (addr_load)
         begin
            case (cmd_op)
               op_program:      exp_len <= page_len;
               op_sector_erase: exp_len <= sector_len;
               op_bulk_erase:   exp_len <= mem_depth;
               default:         exp_len <= exp_len;
            endcase
         end
      end
   end

   // ------------------------------
   // Command flow model
   // ------------------------------

   // Read and page load last until cmd_end
   always_ff @(posedge data_request or posedge read_enable)
   begin
      if (read_enable)
      begin
         reading   <= 1'b0;
         loading   <= 1'b0;
         walk_left <= mem_depth;
      end
      else
      begin
         if (addr_load)
         begin
            reading <= (cmd_op == op_read);
            loading <= (cmd_op == op_program);
         end
         else if (cmd_end)
         begin
            reading <= 1'b0;
            loading <= 1'b0;
         end
         // Walk starts after an accepted erase or the end of a page load
         if (addr_load && cmd_op == op_sector_erase)
         begin
            walk_left <= sector_len;
         end
         else if (addr_load && cmd_op == op_bulk_erase)
         begin
            walk_left <= mem_depth;
         end
         else if (loading && cmd_end)
         begin
            walk_left <= page_len;
         end
         else if (walk_left != 0)
         begin
            walk_left <= walk_left - 1;
         end
      end
   end

   // Strobe in the cycle of cmd_end is dropped
   assign strobe_ok = reading && rd_strobe && !cmd_end;

   // ------------------------------
   // Assertions
   // ------------------------------

   // Data registers one edge after an accepted strobe
   rd_valid_after_strobe: assert property (@(posedge data_request) disable iff (read_enable)
      strobe_ok |=> rd_valid)
   else
   begin
      $error("rd_valid missing one cycle after an accepted rd_strobe");
      prop_errors++;
   end

   rd_valid_only_after_strobe: assert property (@(posedge data_request)
      disable iff (read_enable) rd_valid |-> $past(strobe_ok))
   else
   begin
      $error("rd_valid without an accepted rd_strobe one cycle before");
      prop_errors++;
   end

   busy_length: assert property (@(posedge data_request) disable iff (read_enable)
      $fell(busy) |-> (busy_cnt == exp_len))
   else
   begin
      $error("busy lasted %0d cycles, walk needs %0d", busy_cnt, exp_len);
      prop_errors++;
   end

   // Erase walks start right after the command
   erase_busy_start: assert property (@(posedge data_request) disable iff (read_enable)
      addr_load && (cmd_op == op_sector_erase || cmd_op == op_bulk_erase) |=> busy)
   else
   begin
      $error("busy did not rise one cycle after an erase command");
      prop_errors++;
   end

   no_write_when_idle: assert property (@(posedge data_request) disable iff (read_enable)
      mem_wr |-> (walk_left != 0))
   else
   begin
      $error("array write while no walk is in progress");
      prop_errors++;
   end

endmodule

bind flash_core flash_core_properties #(
   .mem_depth  (mem_depth),
   .page_len   (page_len),
   .sector_len (sector_len)
) u_flash_core_properties (
   .data_request (data_request),
   .read_enable  (read_enable),
   .cmd_op       (cmd_op),
   .cmd_end      (cmd_end),
   .rd_strobe    (rd_strobe),
   .addr_load    (addr_load),
   .mem_wr       (mem_wr),
   .rd_valid     (rd_valid),
   .busy         (busy)
);

// ==== tb/flash_core_tb.sv ====
// Flash core testbench
// Reset fill, page program with wrap and AND, wrapping read,
// sector erase and bulk erase against a shadow byte model

`timescale 1ns/1ps

module flash_core_tb
   import flash_pkg::*;
();

   localparam int mem_depth  = 1024;
   localparam int page_len   = 16;
   localparam int sector_len = 256;
   localparam int addr_w     = $clog2(mem_depth);
   localparam int pg_w       = $clog2(page_len);
   localparam int clk_ns     = 4;

   // Init and bulk walks, one sector, up to eight pages
   localparam int walk_cycles  = 2 * mem_depth + sector_len + 8 * page_len;
   // Three full sweeps plus the short reads
   localparam int read_cycles  = 3 * mem_depth + 64;
   localparam int limit_cycles = 2 * (walk_cycles + read_cycles) + 500;

   logic              data_request;
   logic              read_enable;
   logic              cmd_start;
   flash_op_t         cmd_op;
   logic [addr_w-1:0] cmd_addr;
   logic              cmd_end;
   logic              wr_strobe;
   logic [data_w-1:0] wr_data;
   logic              rd_strobe;
   logic [data_w-1:0] rd_data;
   logic              rd_valid;
   logic              busy;

   // Expected array contents
   logic [data_w-1:0] shadow [mem_depth];
   logic [31:0]       lcg_state;
   int                errors;

   flash_core #(
      .mem_depth  (mem_depth),
      .page_len   (page_len),
      .sector_len (sector_len)
   ) u_flash_core (
      .data_request (data_request),
      .read_enable  (read_enable),
      .cmd_start    (cmd_start),
      .cmd_op       (cmd_op),
      .cmd_addr     (cmd_addr),
      .cmd_end      (cmd_end),
      .wr_strobe    (wr_strobe),
      .wr_data      (wr_data),
      .rd_strobe    (rd_strobe),
      .rd_data      (rd_data),
      .rd_valid     (rd_valid),
      .busy         (busy)
   );

   initial
   begin
      data_request = 1'b0;
      forever
      begin
         #(clk_ns / 2) data_request = ~data_request;
      end
   end

   // Watchdog
   initial
   begin
      #(limit_cycles * clk_ns);
      $display("Timeout after %0d cycles, the run did not finish", limit_cycles);
      $display("*** TEST FAILED ***");
      $finish;
   end

   // ------------------------------
   // Stimulus helpers
   // ------------------------------

   function automatic logic [data_w-1:0] rand_byte();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[23:16];
   endfunction

   task automatic issue_cmd(input flash_op_t op, input logic [addr_w-1:0] addr);
      cmd_op    = op;
      cmd_addr  = addr;
      cmd_start = 1'b1;
      @(negedge data_request);
      cmd_start = 1'b0;
   endtask

   task automatic finish_cmd();
      cmd_end = 1'b1;
      @(negedge data_request);
      cmd_end = 1'b0;
   endtask

   task automatic wait_while_busy();
      while (busy)
      begin
         @(negedge data_request);
      end
   endtask

   // Back-to-back strobes, one read always in flight
   task automatic check_read(input string test, input logic [addr_w-1:0] addr,
                             input int count);
      logic [addr_w-1:0] a;
      a = addr;
      issue_cmd(op_read, addr);
      rd_strobe = 1'b1;
      for (int i = 0; i < count; i++)
      begin
         @(negedge data_request);
         assert (rd_valid === 1'b1)
         else
         begin
            $display("FAIL %s rd_valid addr %h expected 1 actual %b", test, a, rd_valid);
            errors++;
         end
         assert (rd_data === shadow[a])
         else
         begin
            $display("FAIL %s addr %h expected %h actual %h", test, a, shadow[a], rd_data);
            errors++;
         end
         // Top of memory rolls to zero
         a = a + addr_w'(1);
      end
      rd_strobe = 1'b0;
      finish_cmd();
      assert (rd_data === '0)
      else
      begin
         $display("FAIL %s after cmd_end expected 00 actual %h", test, rd_data);
         errors++;
      end
   endtask

   // Load bytes at a wrapping in-page index, then AND the page into the model
   task automatic program_page(input logic [addr_w-1:0] addr, input int count);
      logic [data_w-1:0] page [page_len];
      logic [pg_w-1:0]   idx;
      logic [addr_w-1:0] base;
      for (int i = 0; i < page_len; i++)
      begin
         page[i] = '1;
      end
      idx  = pg_w'(addr % page_len);
      base = addr_w'((addr / page_len) * page_len);
      issue_cmd(op_program, addr);
      for (int i = 0; i < count; i++)
      begin
         wr_data   = rand_byte();
         page[idx] = wr_data;
         wr_strobe = 1'b1;
         idx       = idx + 1'b1;
         @(negedge data_request);
      end
      wr_strobe = 1'b0;
      finish_cmd();
      for (int i = 0; i < page_len; i++)
      begin
         shadow[base + addr_w'(i)] = shadow[base + addr_w'(i)] & page[i];
      end
      wait_while_busy();
   endtask

   task automatic erase_sector(input logic [addr_w-1:0] addr);
      logic [addr_w-1:0] base;
      base = addr_w'((addr / sector_len) * sector_len);
      issue_cmd(op_sector_erase, addr);
      for (int i = 0; i < sector_len; i++)
      begin
         shadow[base + addr_w'(i)] = '1;
      end
      wait_while_busy();
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------

   initial
   begin
      int prop_fails;
      cmd_start   = 1'b0;
      cmd_op      = op_read;
      cmd_addr    = '0;
      cmd_end     = 1'b0;
      wr_strobe   = 1'b0;
      wr_data     = '0;
      rd_strobe   = 1'b0;
      read_enable = 1'b1;
      errors      = 0;
      lcg_state   = 32'h76d441f1;
      for (int i = 0; i < mem_depth; i++)
      begin
         shadow[i] = '1;
      end
      repeat (10) @(negedge data_request);
      read_enable = 1'b0;

      // Initial erase walk, then every byte reads as ones
      assert (busy === 1'b1)
      else
      begin
         $display("FAIL reset_fill busy expected 1 actual %b", busy);
         errors++;
      end
      wait_while_busy();
      check_read("reset_fill", '0, mem_depth);

      // Offsets 5 and 12 both wrap inside page 0x0F0, second pass ANDs
      program_page(10'h0F5, 14);
      program_page(10'h0FC, 10);
      check_read("page_program", 10'h0E8, 32);

      // Data on both sides of the top so the wrap is visible
      program_page(10'h3F8, 16);
      program_page(10'h003, 5);
      check_read("read_wrap", 10'h3FA, 12);

      // Sector 1 cleared, pages in sectors 0 and 2 kept
      program_page(10'h100, 16);
      program_page(10'h1F4, 16);
      program_page(10'h200, 16);
      erase_sector(10'h1A5);
      check_read("sector_erase", '0, mem_depth);

      // Commands and strobes during the walk must be dropped
      issue_cmd(op_bulk_erase, 10'h155);
      repeat (20) @(negedge data_request);
      issue_cmd(op_program, 10'h040);
      wr_data   = 8'h00;
      wr_strobe = 1'b1;
      rd_strobe = 1'b1;
      @(negedge data_request);
      wr_strobe = 1'b0;
      rd_strobe = 1'b0;
      issue_cmd(op_sector_erase, 10'h300);
      for (int i = 0; i < mem_depth; i++)
      begin
         shadow[i] = '1;
      end
      wait_while_busy();
      check_read("bulk_erase", '0, mem_depth);

      prop_fails = u_flash_core.u_flash_core_properties.prop_errors;
      $display("Run complete: %0d check errors, %0d property errors", errors, prop_fails);
      if (errors == 0 && prop_fails == 0)
      begin
         $display("*** TEST PASSED ***");
      end
      else
      begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== verilog/addr_counter.sv ====
// Current byte address of the flash core
// Loaded by each command, stepped by reads with wrap at the top,
// and masked down to the page and sector base

`timescale 1ns/1ps

module addr_counter
#(
   parameter int mem_depth  = 1024,
   parameter int page_len   = 16,
   parameter int sector_len = 256,
   localparam int addr_w    = $clog2(mem_depth)
)
(
   input  logic              data_request,
   input  logic              read_enable,
   input  logic              addr_load,
   input  logic              addr_inc,
   input  logic [addr_w-1:0] cmd_addr,
   output logic [addr_w-1:0] cur_addr,
   output logic [addr_w-1:0] page_base,
   output logic [addr_w-1:0] sector_base
);

   // Top address of the array
   localparam logic [addr_w-1:0] top_addr    = addr_w'(mem_depth - 1);

   // Masks clear the in-page and in-sector bits
   localparam logic [addr_w-1:0] page_mask   = ~addr_w'(page_len - 1);
   localparam logic [addr_w-1:0] sector_mask = ~addr_w'(sector_len - 1);

   // ------------------------------
   // Address register
   // ------------------------------

   always_ff @(posedge data_request or posedge read_enable)
   begin
      if (read_enable)
      begin
         // Initial walk runs from base zero
         cur_addr <= '0;
      end
      else if (addr_load)
      begin
         cur_addr <= cmd_addr;
      end
      else if (addr_inc)
      begin
         // Roll over at the end of the array
         if (cur_addr == top_addr)
         begin
            cur_addr <= '0;
         end
         else
         begin
            cur_addr <= cur_addr + 1'b1;
         end
      end
   end

   // Aligned bases for the write walks
   assign page_base   = cur_addr & page_mask;
   assign sector_base = cur_addr & sector_mask;

endmodule

// ==== verilog/flash_core.sv ====
// Serial NOR flash storage core, parallel command side
// Read streaming, page program and sector and bulk erase
// over one byte array, with an erase walk after reset

`timescale 1ns/1ps

module flash_core
   import flash_pkg::*;
#(
   parameter int mem_depth  = 1024,
   parameter int page_len   = 16,
   parameter int sector_len = 256,
   localparam int addr_w    = $clog2(mem_depth),
   localparam int pg_w      = $clog2(page_len)
)
(
   input  logic              data_request,
   input  logic              read_enable,
   input  logic              cmd_start,
   input  flash_op_t         cmd_op,
   input  logic [addr_w-1:0] cmd_addr,
   input  logic              cmd_end,
   input  logic              wr_strobe,
   input  logic [data_w-1:0] wr_data,
   input  logic              rd_strobe,
   output logic [data_w-1:0] rd_data,
   output logic              rd_valid,
   output logic              busy
);

   // Controller strobes
   logic              addr_load;
   logic              addr_inc;
   logic              buf_clear;
   logic              buf_load;
   logic              mem_rd;
   logic              mem_wr;
   logic              mem_wr_sel;
   logic              mem_wr_base_sel;
   logic              rd_clear;
   logic [addr_w-1:0] walk_idx;

   // Address and data paths
   logic [addr_w-1:0] cur_addr;
   logic [addr_w-1:0] page_base;
   logic [addr_w-1:0] sector_base;
   logic [data_w-1:0] buf_byte;

   // ------------------------------
   // Control
   // ------------------------------

   flash_ctrl #(
      .mem_depth  (mem_depth),
      .page_len   (page_len),
      .sector_len (sector_len)
   ) u_flash_ctrl (
      .data_request    (data_request),
      .read_enable     (read_enable),
      .cmd_start       (cmd_start),
      .cmd_op          (cmd_op),
      .cmd_end         (cmd_end),
      .wr_strobe       (wr_strobe),
      .rd_strobe       (rd_strobe),
      .addr_load       (addr_load),
      .addr_inc        (addr_inc),
      .buf_clear       (buf_clear),
      .buf_load        (buf_load),
      .walk_idx        (walk_idx),
      .mem_rd          (mem_rd),
      .mem_wr          (mem_wr),
      .mem_wr_sel      (mem_wr_sel),
      .mem_wr_base_sel (mem_wr_base_sel),
      .rd_valid        (rd_valid),
      .rd_clear        (rd_clear),
      .busy            (busy)
   );

   // ------------------------------
   // Datapath
   // ------------------------------

   addr_counter #(
      .mem_depth  (mem_depth),
      .page_len   (page_len),
      .sector_len (sector_len)
   ) u_addr_counter (
      .data_request (data_request),
      .read_enable  (read_enable),
      .addr_load    (addr_load),
      .addr_inc     (addr_inc),
      .cmd_addr     (cmd_addr),
      .cur_addr     (cur_addr),
      .page_base    (page_base),
      .sector_base  (sector_base)
   );

   // In-page start index is the low address bits
   page_buffer #(
      .page_len (page_len)
   ) u_page_buffer (
      .data_request (data_request),
      .read_enable  (read_enable),
      .buf_clear    (buf_clear),
      .buf_load     (buf_load),
      .start_idx    (cmd_addr[pg_w-1:0]),
      .wr_data      (wr_data),
      .walk_idx     (walk_idx[pg_w-1:0]),
      .buf_byte     (buf_byte)
   );

   // Write address is the selected base plus walk index, wrapping at top
   memory_array #(
      .mem_depth (mem_depth)
   ) u_memory_array (
      .data_request (data_request),
      .read_enable  (read_enable),
      .mem_rd       (mem_rd),
      .rd_addr      (cur_addr),
      .rd_clear     (rd_clear),
      .mem_wr       (mem_wr),
      .wr_sel       (mem_wr_sel),
      .wr_addr      (mem_wr_base_sel ? sector_base + walk_idx : page_base + walk_idx),
      .wr_byte      (buf_byte),
      .rd_data      (rd_data)
   );

endmodule

// ==== verilog/flash_ctrl.sv ====
// Flash command controller
// Decodes commands, streams reads, collects page data and
// runs the program and erase walks that hold busy high

`timescale 1ns/1ps

module flash_ctrl
   import flash_pkg::*;
#(
   parameter int mem_depth  = 1024,
   parameter int page_len   = 16,
   parameter int sector_len = 256,
   localparam int addr_w    = $clog2(mem_depth)
)
(
   input  logic              data_request,
   input  logic              read_enable,
   input  logic              cmd_start,
   input  flash_op_t         cmd_op,
   input  logic              cmd_end,
   input  logic              wr_strobe,
   input  logic              rd_strobe,
   output logic              addr_load,
   output logic              addr_inc,
   output logic              buf_clear,
   output logic              buf_load,
   output logic [addr_w-1:0] walk_idx,
   output logic              mem_rd,
   output logic              mem_wr,
   output logic              mem_wr_sel,
   output logic              mem_wr_base_sel,
   output logic              rd_valid,
   output logic              rd_clear,
   output logic              busy
);

   // Last walk index for each walk type
   localparam logic [addr_w-1:0] page_last   = addr_w'(page_len - 1);
   localparam logic [addr_w-1:0] sector_last = addr_w'(sector_len - 1);
   localparam logic [addr_w-1:0] mem_last    = addr_w'(mem_depth - 1);

   ctrl_state_t       state_q;
   ctrl_state_t       state_d;
   logic [addr_w-1:0] walk_cnt;
   logic [addr_w-1:0] walk_last;
   logic              walk_done;
   logic              start_ok;
   logic              rd_acc;

   // ------------------------------
   // Command acceptance
   // ------------------------------

   // New commands only from idle
   assign start_ok  = cmd_start && (state_q == st_idle);

   // A read strobe together with cmd_end is dropped, the end wins
   assign rd_acc    = (state_q == st_read) && rd_strobe && !cmd_end;

   assign addr_load = start_ok;
   assign buf_clear = start_ok && (cmd_op == op_program);
   assign buf_load  = (state_q == st_load) && wr_strobe;
   assign mem_rd    = rd_acc;
   assign addr_inc  = rd_acc;
   assign rd_clear  = (state_q == st_read) && cmd_end;

   // ------------------------------
   // Walk control
   // ------------------------------

   // All four walk states hold busy
   assign busy = (state_q == st_init) || (state_q == st_program) ||
                 (state_q == st_sector_erase) || (state_q == st_bulk_erase);

   always_comb
   begin
      case (state_q)
         st_program:      walk_last = page_last;
         st_sector_erase: walk_last = sector_last;
         default:         walk_last = mem_last;
      endcase
   end

   assign walk_done = busy && (walk_cnt == walk_last);

   // Array written once per walk cycle
   assign mem_wr          = busy;
   // Program ANDs buffer data, everything else writes ones
   assign mem_wr_sel      = (state_q != st_program);
   // Page base for program, sector base otherwise
   // (bulk walk over mem_depth wraps through every address)
   assign mem_wr_base_sel = (state_q != st_program);
   assign walk_idx        = walk_cnt;

   // Back to zero at walk end, so each walk starts at index 0
   always_ff @(posedge data_request or posedge read_enable)
   begin
      if (read_enable)
      begin
         walk_cnt <= '0;
      end
      else if (busy)
      begin
         walk_cnt <= walk_done ? '0 : walk_cnt + 1'b1;
      end
   end

   // ------------------------------
   // State machine
   // ------------------------------

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         st_idle:
         begin
            if (start_ok)
            begin
               case (cmd_op)
                  op_read:         state_d = st_read;
                  op_program:      state_d = st_load;
                  op_sector_erase: state_d = st_sector_erase;
                  default:         state_d = st_bulk_erase;
               endcase
            end
         end
         st_read:
         begin
            if (cmd_end)
            begin
               state_d = st_idle;
            end
         end
         st_load:
         begin
            // Program walk begins on the next edge
            if (cmd_end)
            begin
               state_d = st_program;
            end
         end
         default:
         begin
            if (walk_done)
            begin
               state_d = st_idle;
            end
         end
      endcase
   end

   // Reset lands in the initial bulk erase walk
   always_ff @(posedge data_request or posedge read_enable)
   begin
      if (read_enable)
      begin
         state_q  <= st_init;
         rd_valid <= 1'b0;
      end
      else
      begin
         state_q  <= state_d;
         // Data registers in the array on this same edge
         rd_valid <= rd_acc;
      end
   end

endmodule

// ==== verilog/flash_pkg.sv ====
// Flash storage core shared definitions
// Byte width, command opcodes and controller states

package flash_pkg;

   // ------------------------------
   // Data path
   // ------------------------------

   // Every block stores and moves whole bytes
   localparam int data_w = 8;

   // ------------------------------
   // Command opcodes
   // ------------------------------

   // Decoded from the serial instruction byte upstream
   typedef enum logic [1:0] {
      // Stream bytes from consecutive addresses
      op_read         = 2'd0,
      // Load page buffer, then AND into one page
      op_program      = 2'd1,
      // One aligned sector to all ones
      op_sector_erase = 2'd2,
      // Whole array to all ones
      op_bulk_erase   = 2'd3
   } flash_op_t;

   // ------------------------------
   // Controller states
   // ------------------------------

   typedef enum logic [2:0] {
      st_init         = 3'd0,   // bulk erase walk after reset
      st_idle         = 3'd1,
      st_read         = 3'd2,   // streaming on rd_strobe
      st_load         = 3'd3,   // filling page buffer
      st_program      = 3'd4,   // page walk, AND into array
      st_sector_erase = 3'd5,
      st_bulk_erase   = 3'd6
   } ctrl_state_t;

endpackage

// ==== verilog/memory_array.sv ====
// Flash byte array
// Registered read port, and a write port that either ANDs in
// program data or sets the byte to all ones for erase

`timescale 1ns/1ps

module memory_array
   import flash_pkg::*;
#(
   parameter int mem_depth = 1024,
   localparam int addr_w   = $clog2(mem_depth)
)
(
   input  logic              data_request,
   input  logic              read_enable,
   input  logic              mem_rd,
   input  logic [addr_w-1:0] rd_addr,
   input  logic              rd_clear,
   input  logic              mem_wr,
   input  logic              wr_sel,
   input  logic [addr_w-1:0] wr_addr,
   input  logic [data_w-1:0] wr_byte,
   output logic [data_w-1:0] rd_data
);

   logic [data_w-1:0] content [mem_depth];

   // ------------------------------
   // Write port
   // ------------------------------

   // Program can only clear bits, erase sets them all
   always_ff @(posedge data_request)
   begin
      if (mem_wr)
      begin
         if (wr_sel)
         begin
            content[wr_addr] <= '1;
         end
         else
         begin
            content[wr_addr] <= content[wr_addr] & wr_byte;
         end
      end
   end

   // ------------------------------
   // Read port
   // ------------------------------

   // End of read drives the output back to zero
   always_ff @(posedge data_request or posedge read_enable)
   begin
      if (read_enable)
      begin
         rd_data <= '0;
      end
      else if (rd_clear)
      begin
         rd_data <= '0;
      end
      else if (mem_rd)
      begin
         rd_data <= content[rd_addr];
      end
   end

endmodule

// ==== verilog/page_buffer.sv ====
// Page program buffer
// Holds one page of bytes, set to ones at command start,
// filled at a running index that wraps inside the page

`timescale 1ns/1ps

module page_buffer
   import flash_pkg::*;
#(
   parameter int page_len = 16,
   localparam int pg_w    = $clog2(page_len)
)
(
   input  logic              data_request,
   input  logic              read_enable,
   input  logic              buf_clear,
   input  logic              buf_load,
   input  logic [pg_w-1:0]   start_idx,
   input  logic [data_w-1:0] wr_data,
   input  logic [pg_w-1:0]   walk_idx,
   output logic [data_w-1:0] buf_byte
);

   logic [data_w-1:0] buf_mem [page_len];
   logic [pg_w-1:0]   wr_idx;

   // ------------------------------
   // Running load index
   // ------------------------------

   // Start from the low address bits, wrap at page end
   always_ff @(posedge data_request or posedge read_enable)
   begin
      if (read_enable)
      begin
         wr_idx <= '0;
      end
      else if (buf_clear)
      begin
         wr_idx <= start_idx;
      end
      else if (buf_load)
      begin
         wr_idx <= wr_idx + 1'b1;
      end
   end

   // ------------------------------
   // Byte storage
   // ------------------------------

   always_ff @(posedge data_request)
   begin
      if (buf_clear)
      begin
         // Unwritten bytes leave the array untouched under AND
         for (int i = 0; i < page_len; i++)
         begin
            buf_mem[i] <= '1;
         end
      end
      else if (buf_load)
      begin
         buf_mem[wr_idx] <= wr_data;
      end
   end

   // Walk reads one byte per cycle
   assign buf_byte = buf_mem[walk_idx];

endmodule
